// File: hdl/arch_regfile.sv
module arch_regfile (
  input  logic             clk_i,
  input  logic             rst_i,
  commit_if.regfile        cmt,
  input  rob_pkg::reg_id_t rd_addr_i,
  output rob_pkg::data_t   rd_data_o
);

  rob_pkg::data_t regs_q [rob_pkg::NUM_REGS];

  // excepting commits arrive with wb low and leave the register untouched.
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < rob_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (cmt.valid && cmt.wb) begin
      regs_q[cmt.reg_id] <= cmt.data;
    end
  end

  assign rd_data_o = regs_q[rd_addr_i];

endmodule : arch_regfile

// File: hdl/exec_unit.sv
module exec_unit (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              dispatch_valid_i,
  input  rob_pkg::rob_idx_t dispatch_idx_i,
  input  rob_pkg::op_t      op_i,
  input  rob_pkg::data_t    opa_i,
  input  rob_pkg::data_t    opb_i,
  complete_if.exec          cpl
);

  logic [rob_pkg::ROB_ENTRIES-1:0] busy_q;
  logic [rob_pkg::ROB_ENTRIES-1:0] busy_d;
  logic [rob_pkg::ROB_ENTRIES-1:0] excp_q;
  rob_pkg::lat_t  cnt_q [rob_pkg::ROB_ENTRIES];
  rob_pkg::data_t res_q [rob_pkg::ROB_ENTRIES];

  rob_pkg::data_t    res_sel;
  rob_pkg::lat_t     lat_sel;
  logic              excp_sel;
  logic              grant_valid;
  rob_pkg::rob_idx_t grant_idx;

  // ############################################################
  // result and latency are settled at dispatch.
  // ############################################################

  always_comb begin
    res_sel  = '0;
    lat_sel  = rob_pkg::lat_t'(1);
    excp_sel = 1'b0;
    case (op_i)
      rob_pkg::OP_ADD: begin
        res_sel = opa_i + opb_i;
        lat_sel = rob_pkg::LAT_ADD;
      end
      rob_pkg::OP_XOR: begin
        res_sel = opa_i ^ opb_i;
        lat_sel = rob_pkg::LAT_XOR;
      end
      rob_pkg::OP_SHL: begin
        res_sel = opa_i << opb_i[4:0];
        lat_sel = rob_pkg::LAT_SHL;
      end
      rob_pkg::OP_MUL: begin
        // only the low word of the product is kept.
        res_sel = opa_i * opb_i;
        lat_sel = rob_pkg::LAT_MUL;
      end
      default: begin
        excp_sel = 1'b1;
      end
    endcase
  end

  // lowest ready slot wins the completion bus.
  always_comb begin
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int i = rob_pkg::ROB_ENTRIES - 1; i >= 0; i--) begin
      if (busy_q[i] && (cnt_q[i] == '0)) begin
        grant_valid = 1'b1;
        grant_idx   = rob_pkg::rob_idx_t'(i);
      end
    end
  end

  assign cpl.valid = grant_valid;
  assign cpl.idx   = grant_idx;
  assign cpl.data  = res_q[grant_idx];
  assign cpl.excp  = grant_valid & excp_q[grant_idx];

  always_comb begin
    busy_d = busy_q;
    if (grant_valid) begin
      busy_d[grant_idx] = 1'b0;
    end
    if (dispatch_valid_i) begin
      busy_d[dispatch_idx_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

  // the countdown is loaded with L-1 so that a slot is ready L cycles after dispatch.
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < rob_pkg::ROB_ENTRIES; i++) begin
      if (cnt_q[i] != '0) begin
        cnt_q[i] <= cnt_q[i] - rob_pkg::lat_t'(1);
      end
    end
    if (dispatch_valid_i) begin
      cnt_q[dispatch_idx_i]  <= lat_sel - rob_pkg::lat_t'(1);
      res_q[dispatch_idx_i]  <= res_sel;
      excp_q[dispatch_idx_i] <= excp_sel;
    end
  end

endmodule : exec_unit

// File: hdl/ooo_core_top.sv
module ooo_core_top (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             dispatch_valid_i,
  input  rob_pkg::op_t     dispatch_op_i,
  input  rob_pkg::reg_id_t dispatch_reg_i,
  input  rob_pkg::data_t   dispatch_opa_i,
  input  rob_pkg::data_t   dispatch_opb_i,
  output logic             full_o,
  output logic             commit_valid_o,
  output rob_pkg::reg_id_t commit_reg_o,
  output rob_pkg::data_t   commit_data_o,
  output logic             commit_excp_o,
  input  rob_pkg::reg_id_t rd_addr_i,
  output rob_pkg::data_t   rd_data_o
);

  rob_pkg::rob_idx_t alloc_idx;

  complete_if cpl_bus ();
  commit_if   cmt_bus ();

  reorder_buffer i_reorder_buffer (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .dispatch_valid_i (dispatch_valid_i),
    .dispatch_reg_i   (dispatch_reg_i),
    .alloc_idx_o      (alloc_idx),
    .full_o           (full_o),
    .cpl              (cpl_bus),
    .cmt              (cmt_bus)
  );

  // the execution slot shares its index with the buffer entry.
  exec_unit i_exec_unit (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .dispatch_valid_i (dispatch_valid_i),
    .dispatch_idx_i   (alloc_idx),
    .op_i             (dispatch_op_i),
    .opa_i            (dispatch_opa_i),
    .opb_i            (dispatch_opb_i),
    .cpl              (cpl_bus)
  );

  arch_regfile i_arch_regfile (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .cmt       (cmt_bus),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o)
  );

  assign commit_valid_o = cmt_bus.valid;
  assign commit_reg_o   = cmt_bus.reg_id;
  assign commit_data_o  = cmt_bus.data;
  assign commit_excp_o  = cmt_bus.excp;

endmodule : ooo_core_top

// File: hdl/reorder_buffer.sv
module reorder_buffer (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              dispatch_valid_i,
  input  rob_pkg::reg_id_t  dispatch_reg_i,
  output rob_pkg::rob_idx_t alloc_idx_o,
  output logic              full_o,
  complete_if.rob           cpl,
  commit_if.rob             cmt
);

  // per-entry payload.
  rob_pkg::reg_id_t dest_q [rob_pkg::ROB_ENTRIES];
  rob_pkg::data_t   data_q [rob_pkg::ROB_ENTRIES];
  logic [rob_pkg::ROB_ENTRIES-1:0] excp_q;

  // per-entry control.
  logic [rob_pkg::ROB_ENTRIES-1:0] done_q;
  logic [rob_pkg::ROB_ENTRIES-1:0] done_d;

  rob_pkg::rob_idx_t head_q;
  rob_pkg::rob_idx_t tail_q;
  rob_pkg::rob_idx_t head_nxt;
  rob_pkg::rob_idx_t tail_nxt;
  logic              head_done;

  // ############################################################
  // pointers and allocation.
  // ############################################################

  // the entry count is a power of two, so the pointers wrap on their own.
  assign head_nxt  = head_q + rob_pkg::rob_idx_t'(1);
  assign tail_nxt  = tail_q + rob_pkg::rob_idx_t'(1);
  assign head_done = done_q[head_q];

  assign alloc_idx_o = tail_q;

  // one slot stays empty so that full and empty can be told apart.
  assign full_o = (tail_nxt == head_q);

  // ############################################################
  // commit from the head entry.
  // ############################################################

  always_comb begin
    cmt.valid  = head_done;
    cmt.excp   = head_done & excp_q[head_q];
    cmt.wb     = head_done & ~excp_q[head_q];
    cmt.reg_id = dest_q[head_q];
    cmt.data   = data_q[head_q];
  end

  // finished flags for the next cycle.
  always_comb begin
    done_d = done_q;
    if (dispatch_valid_i) begin
      done_d[tail_q] = 1'b0;
    end
    if (cpl.valid) begin
      done_d[cpl.idx] = 1'b1;
    end
    if (head_done) begin
      done_d[head_q] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      head_q <= '0;
      tail_q <= '0;
      done_q <= '0;
    end else begin
      done_q <= done_d;
      if (dispatch_valid_i) begin
        tail_q <= tail_nxt;
      end
      if (head_done) begin
        head_q <= head_nxt;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dispatch_valid_i) begin
      dest_q[tail_q] <= dispatch_reg_i;
    end
    if (cpl.valid) begin
      data_q[cpl.idx] <= cpl.data;
      excp_q[cpl.idx] <= cpl.excp;
    end
  end

endmodule : reorder_buffer

// File: hdl/rob_if.sv
interface complete_if;
  logic              valid;
  rob_pkg::rob_idx_t idx;
  rob_pkg::data_t    data;
  logic              excp;

  modport exec (output valid, idx, data, excp);
  modport rob  (input  valid, idx, data, excp);
endinterface : complete_if

interface commit_if;
  logic             valid;
  logic             wb;
  rob_pkg::reg_id_t reg_id;
  rob_pkg::data_t   data;
  logic             excp;

  modport rob     (output valid, wb, reg_id, data, excp);
  // the register file never looks at the exception flag, wb already covers it.
  modport regfile (input  valid, wb, reg_id, data);
endinterface : commit_if

// File: hdl/rob_pkg.sv
package rob_pkg;

  // ############################################################
  // widths and sizes.
  // ############################################################

  localparam int DATA_W      = 32;
  localparam int NUM_REGS    = 16;
  localparam int ROB_ENTRIES = 8;
  localparam int REG_ID_W    = $clog2(NUM_REGS);
  localparam int ROB_IDX_W   = $clog2(ROB_ENTRIES);
  localparam int OP_W        = 3;
  localparam int LAT_W       = 3;

  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [REG_ID_W-1:0]  reg_id_t;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [OP_W-1:0]      op_t;
  typedef logic [LAT_W-1:0]     lat_t;

  // ############################################################
  // opcodes and their execution latencies.
  // ############################################################

  localparam op_t OP_ADD = 3'd0;
  localparam op_t OP_XOR = 3'd1;
  localparam op_t OP_SHL = 3'd2;
  localparam op_t OP_MUL = 3'd3;

  // cycles from dispatch until the slot may complete.
  localparam lat_t LAT_ADD = 3'd1;
  localparam lat_t LAT_XOR = 3'd1;
  localparam lat_t LAT_SHL = 3'd2;
  localparam lat_t LAT_MUL = 3'd4;

endpackage : rob_pkg

// File: ooo_core_top.f
hdl/rob_pkg.sv
hdl/rob_if.sv
hdl/reorder_buffer.sv
hdl/exec_unit.sv
hdl/arch_regfile.sv
hdl/ooo_core_top.sv
verification/ooo_core_checker.sv
verification/ooo_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ooo_core_tb -Mdir obj_dir \
  -f ooo_core_top.f
./obj_dir/Vooo_core_tb | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run_sim: testbench reported a failure"
  exit 1
fi
echo "run_sim: testbench passed"

// File: verification/ooo_core_checker.sv
module ooo_core_checker (
  input logic clk_i,
  input logic rst_i,
  input logic dispatch_valid_i,
  input logic full_o,
  input logic commit_valid_o,
  input logic commit_excp_o
);

  // there is no back-pressure, so a dispatch into a full buffer would be lost.
  no_dispatch_when_full: assert property (@(posedge clk_i) disable iff (!rst_i)
    full_o |-> !dispatch_valid_i)
    else $error("dispatch_valid_i asserted while full_o is high");

  commit_valid_known: assert property (@(posedge clk_i) disable iff (!rst_i)
    !$isunknown(commit_valid_o))
    else $error("commit_valid_o is unknown after reset");

  excp_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_i)
    commit_excp_o |-> commit_valid_o)
    else $error("commit_excp_o high without commit_valid_o");

  // first cycle out of reset.
  quiet_after_reset: assert property (@(posedge clk_i)
    $rose(rst_i) |-> (!full_o && !commit_valid_o))
    else $error("full_o or commit_valid_o high right after reset");

endmodule : ooo_core_checker

bind ooo_core_top ooo_core_checker i_ooo_core_checker (
  .clk_i            (clk_i),
  .rst_i            (rst_i),
  .dispatch_valid_i (dispatch_valid_i),
  .full_o           (full_o),
  .commit_valid_o   (commit_valid_o),
  .commit_excp_o    (commit_excp_o)
);

// File: verification/ooo_core_tb.sv
module ooo_core_tb;

  localparam int MEM_WORDS = 256;
  localparam int MAX_RECS  = 64;

  logic             clk_i = 1'b0;
  logic             rst_i;
  logic             dispatch_valid_i;
  rob_pkg::op_t     dispatch_op_i;
  rob_pkg::reg_id_t dispatch_reg_i;
  rob_pkg::data_t   dispatch_opa_i;
  rob_pkg::data_t   dispatch_opb_i;
  logic             full_o;
  logic             commit_valid_o;
  rob_pkg::reg_id_t commit_reg_o;
  rob_pkg::data_t   commit_data_o;
  logic             commit_excp_o;
  rob_pkg::reg_id_t rd_addr_i;
  rob_pkg::data_t   rd_data_o;

  // records point at their first word in vec_mem.
  logic [31:0] vec_mem [MEM_WORDS];
  int          ins_ptr [MAX_RECS];
  int          fin_ptr [MAX_RECS];
  int          n_instr = 0;
  int          n_final = 0;
  int          commit_cnt = 0;
  int          occ = 0;
  int          cycles = 0;
  int          timeout_limit = 1000000;
  logic        saw_full = 1'b0;
  logic [31:0] lfsr_q;

  ooo_core_top i_ooo_core_top (.*);

  always #4 clk_i = ~clk_i;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic load_vectors();
    int p;
    p = 0;
    $readmemh("verification/ooo_core_vectors.txt", vec_mem);
    while ((p < MEM_WORDS - 7) && (vec_mem[p] != 32'h0)) begin
      if (vec_mem[p] == 32'h4) begin
        fin_ptr[n_final] = p;
        n_final++;
        p += 3;
      end else begin
        ins_ptr[n_instr] = p;
        n_instr++;
        p += 7;
      end
    end
    if (n_instr == 0) report_failure("the vector file holds no instructions");
  endtask

  // ##########################################################
  // commit monitor and occupancy model, sampled mid-cycle.
  // ##########################################################

  always @(negedge clk_i) begin
    if (rst_i) begin
      compare("full_o", {31'h0, full_o}, (occ == rob_pkg::ROB_ENTRIES - 1) ? 32'h1 : 32'h0);
      saw_full = saw_full | full_o;
      if (commit_valid_o) begin
        if (commit_cnt >= n_instr) report_failure("a commit arrived after the last instruction");
        compare("commit_reg_o", {28'h0, commit_reg_o}, vec_mem[ins_ptr[commit_cnt] + 2]);
        compare("commit_excp_o", {31'h0, commit_excp_o}, vec_mem[ins_ptr[commit_cnt] + 6]);
        if (vec_mem[ins_ptr[commit_cnt] + 6] == 32'h0) begin
          compare("commit_data_o", commit_data_o, vec_mem[ins_ptr[commit_cnt] + 5]);
        end
        commit_cnt++;
      end
      occ = occ + (dispatch_valid_i ? 1 : 0) - (commit_valid_o ? 1 : 0);
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > timeout_limit) report_failure("timeout: the instruction stream never finished");
  end

  initial begin
    int gap;
    int k;
    lfsr_q = 32'h4c99;
    rst_i = 1'b0;
    dispatch_valid_i = 1'b0;
    dispatch_op_i = '0;
    dispatch_reg_i = '0;
    dispatch_opa_i = '0;
    dispatch_opb_i = '0;
    rd_addr_i = '0;
    load_vectors();
    timeout_limit = n_instr * (int'(rob_pkg::LAT_MUL) + 4) + 100;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b1;
    for (k = 0; k < n_instr; k++) begin
      gap = 0;
      if (vec_mem[ins_ptr[k]] == 32'h1) begin
        lfsr_q = lfsr_step(lfsr_q);
        gap = int'(lfsr_q[0]);
        lfsr_q = lfsr_step(lfsr_q);
        gap = gap + 2 * int'(lfsr_q[0]);
      end
      repeat (gap) begin
        @(posedge clk_i);
        dispatch_valid_i <= 1'b0;
      end
      @(posedge clk_i);
      // occ already holds the count for the cycle that starts here.
      while ((occ >= rob_pkg::ROB_ENTRIES - 1) ||
             ((vec_mem[ins_ptr[k]] == 32'h3) && (occ != 0))) begin
        dispatch_valid_i <= 1'b0;
        @(posedge clk_i);
      end
      dispatch_valid_i <= 1'b1;
      dispatch_op_i    <= vec_mem[ins_ptr[k] + 1][2:0];
      dispatch_reg_i   <= vec_mem[ins_ptr[k] + 2][3:0];
      dispatch_opa_i   <= vec_mem[ins_ptr[k] + 3];
      dispatch_opb_i   <= vec_mem[ins_ptr[k] + 4];
    end
    @(posedge clk_i);
    dispatch_valid_i <= 1'b0;
    wait (commit_cnt == n_instr);
    for (k = 0; k < n_final; k++) begin
      @(posedge clk_i);
      rd_addr_i <= vec_mem[fin_ptr[k] + 1][3:0];
      @(negedge clk_i);
      compare($sformatf("rd_data_o[r%0d]", vec_mem[fin_ptr[k] + 1]), rd_data_o,
              vec_mem[fin_ptr[k] + 2]);
    end
    if (!saw_full) begin
      report_failure("full_o never went high during the dispatch burst");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule : ooo_core_tb

// File: verification/ooo_core_vectors.txt
// instruction: mode op dst opa opb expected_data expected_excp
// mode 1 random gap, 2 back-to-back, 3 wait for an empty buffer; final: 4 reg value; 0 ends.
1 3 1 00000007 00000006 0000002a 0
1 0 2 00000010 00000020 00000030 0
1 0 3 ffffffff 00000002 00000001 0
1 1 4 f0f0f0f0 0ff00ff0 ff00ff00 0
1 2 5 00000003 00000024 00000030 0
1 5 2 00000011 00000022 00000000 1
1 3 6 12345678 00000010 23456780 0
// the head multiply sits in slot 7 and loses the bus to the younger adds.
3 3 7 00010001 00010001 00020001 0
2 0 8 00000001 00000001 00000002 0
2 0 9 00000003 00000004 00000007 0
2 1 a aaaa5555 ffff0000 55555555 0
2 0 b 00000100 00000200 00000300 0
2 1 c 0000ffff 00000f0f 0000f0f0 0
2 0 d 7fffffff 00000001 80000000 0
2 3 e 00000100 00000100 00010000 0
2 2 f 00000001 0000001f 80000000 0
2 0 1 00000005 00000005 0000000a 0
1 7 3 00000001 00000001 00000000 1
1 2 0 deadbeef 00000020 deadbeef 0
1 0 9 fffffff0 00000020 00000010 0
4 0 deadbeef
4 1 0000000a
4 2 00000030
4 3 00000001
4 7 00020001
4 9 00000010
4 d 80000000
4 e 00010000
0
